// File: rtl/cpu_isa_pkg.sv
package cpu_isa_pkg;

    localparam int DATA_W    = 16;
    localparam int REG_CNT   = 8;
    localparam int REG_SEL_W = 3;
    localparam int FLAG_CNT  = 5;

    // Bit positions in the flag register
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_O = 3;
    localparam int FLAG_P = 4;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SHL    = 3'd5,
        ALU_SHR    = 3'd6,
        ALU_PASS_R = 3'd7
    } alu_mode_t;

    // Jump code with the valid bit on top
    typedef logic [4:0] jump_cond_t;

    localparam int JC_VALID_BIT = 4;

    localparam jump_cond_t JC_UNCOND = 5'b10000;
    localparam jump_cond_t JC_CARRY  = 5'b10001;
    localparam jump_cond_t JC_EQ     = 5'b10010;
    localparam jump_cond_t JC_LT     = 5'b10011;
    localparam jump_cond_t JC_GT     = 5'b10100;
    localparam jump_cond_t JC_LE     = 5'b10101;
    localparam jump_cond_t JC_GE     = 5'b10110;
    localparam jump_cond_t JC_NE     = 5'b10111;
    localparam jump_cond_t JC_OVF    = 5'b11000;
    localparam jump_cond_t JC_PAR    = 5'b11001;
    localparam jump_cond_t JC_GTU    = 5'b11010;
    localparam jump_cond_t JC_GEU    = 5'b11011;
    localparam jump_cond_t JC_LEU    = 5'b11100;

    localparam logic [DATA_W-1:0] PC_RESET = '0;

endpackage

// File: rtl/exec_pipe_pkg.sv
package exec_pipe_pkg;

    import cpu_isa_pkg::*;

    // Decoded operation from the decode stage
    typedef struct packed {
        alu_mode_t            alu_mode;
        logic                 carry_en;
        logic [REG_SEL_W-1:0] l_sel;
        logic [REG_SEL_W-1:0] r_sel;
        logic                 use_imm;
        logic [DATA_W-1:0]    imm;
        logic [REG_SEL_W-1:0] dst_sel;
        logic                 dst_we;
        logic                 flags_we;
        jump_cond_t           jump_code;
        logic                 predict;
    } exec_op_t;

    // Result handed to the next stage
    typedef struct packed {
        logic [DATA_W-1:0]    data;
        logic [REG_SEL_W-1:0] dst_sel;
        logic                 we;
    } exec_result_t;

    typedef struct packed {
        logic                 we;
        logic [REG_SEL_W-1:0] sel;
        logic [DATA_W-1:0]    data;
    } wb_t;

    typedef struct packed {
        logic is_jump;
        logic taken;
        logic mispredict;
    } branch_dec_t;

endpackage

// File: rtl/reg_file.sv
module reg_file (
    input  logic                              i_clk,
    input  logic                              i_rst,
    input  logic [cpu_isa_pkg::REG_SEL_W-1:0] i_l_sel,
    input  logic [cpu_isa_pkg::REG_SEL_W-1:0] i_r_sel,
    input  exec_pipe_pkg::wb_t                i_wb,
    output logic [cpu_isa_pkg::DATA_W-1:0]    o_l_data,
    output logic [cpu_isa_pkg::DATA_W-1:0]    o_r_data
);

    import cpu_isa_pkg::*;

    logic [DATA_W-1:0] regs [REG_CNT];

    // A write in flight is visible to the reads of the same cycle
    function automatic logic [DATA_W-1:0] read_port(input logic [REG_SEL_W-1:0] sel);
        if (i_wb.we && (i_wb.sel == sel)) begin
            return i_wb.data;
        end
        return regs[sel];
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.we) begin
            regs[i_wb.sel] <= i_wb.data;
        end
    end

    always_comb begin
        o_l_data = read_port(i_l_sel);
        o_r_data = read_port(i_r_sel);
    end

endmodule

// File: rtl/alu.sv
module alu (
    input  logic [cpu_isa_pkg::DATA_W-1:0]   i_l,
    input  logic [cpu_isa_pkg::DATA_W-1:0]   i_r,
    input  cpu_isa_pkg::alu_mode_t           i_mode,
    input  logic                             i_carry,
    output logic [cpu_isa_pkg::DATA_W-1:0]   o_out,
    output logic [cpu_isa_pkg::FLAG_CNT-1:0] o_flags
);

    import cpu_isa_pkg::*;

    logic [DATA_W:0] wide;
    logic            carry;
    logic            ovf;

    always_comb begin
        wide  = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (i_mode)
            ALU_ADD: begin
                wide  = {1'b0, i_l} + {1'b0, i_r} + {{DATA_W{1'b0}}, i_carry};
                carry = wide[DATA_W];
                ovf   = (i_l[DATA_W-1] == i_r[DATA_W-1]) &&
                        (wide[DATA_W-1] != i_l[DATA_W-1]);
            end
            ALU_SUB: begin
                // Top bit of the wide result is the borrow
                wide  = {1'b0, i_l} - {1'b0, i_r};
                carry = wide[DATA_W];
                ovf   = (i_l[DATA_W-1] != i_r[DATA_W-1]) &&
                        (wide[DATA_W-1] != i_l[DATA_W-1]);
            end
            ALU_AND: begin
                wide = {1'b0, i_l & i_r};
            end
            ALU_OR: begin
                wide = {1'b0, i_l | i_r};
            end
            ALU_XOR: begin
                wide = {1'b0, i_l ^ i_r};
            end
            ALU_SHL: begin
                wide  = {1'b0, i_l[DATA_W-2:0], 1'b0};
                carry = i_l[DATA_W-1];
            end
            ALU_SHR: begin
                wide  = {2'b00, i_l[DATA_W-1:1]};
                carry = i_l[0];
            end
            ALU_PASS_R: begin
                wide = {1'b0, i_r};
            end
            default: begin
                wide = '0;
            end
        endcase
    end

    assign o_out = wide[DATA_W-1:0];

    always_comb begin
        o_flags         = '0;
        o_flags[FLAG_Z] = (o_out == '0);
        o_flags[FLAG_C] = carry;
        o_flags[FLAG_N] = o_out[DATA_W-1];
        o_flags[FLAG_O] = ovf;
        // Set for an even number of one bits
        o_flags[FLAG_P] = ~^o_out;
    end

    // Decode must never hand over an unknown mode
    always_comb begin
        assert final (!$isunknown(i_mode))
            else $error("alu: undefined mode %b", i_mode);
    end

endmodule

// File: rtl/branch_unit.sv
module branch_unit (
    input  cpu_isa_pkg::jump_cond_t          i_jump_code,
    input  logic                             i_predict,
    input  logic [cpu_isa_pkg::FLAG_CNT-1:0] i_flags,
    output exec_pipe_pkg::branch_dec_t       o_dec
);

    import cpu_isa_pkg::*;

    logic taken;
    logic z;
    logic c;
    logic n;

    assign z = i_flags[FLAG_Z];
    assign c = i_flags[FLAG_C];
    assign n = i_flags[FLAG_N];

    // Codes without the valid bit and unused codes fall to not taken
    always_comb begin
        case (i_jump_code)
            JC_UNCOND: taken = 1'b1;
            JC_CARRY:  taken = c;
            JC_EQ:     taken = z;
            JC_LT:     taken = n;
            JC_GT:     taken = ~(n | z);
            JC_LE:     taken = n | z;
            JC_GE:     taken = ~n;
            JC_NE:     taken = ~z;
            JC_OVF:    taken = i_flags[FLAG_O];
            JC_PAR:    taken = i_flags[FLAG_P];
            JC_GTU:    taken = ~(c | z);
            JC_GEU:    taken = ~c;
            JC_LEU:    taken = c | z;
            default:   taken = 1'b0;
        endcase
    end

    always_comb begin
        o_dec.is_jump    = i_jump_code[JC_VALID_BIT];
        o_dec.taken      = taken;
        o_dec.mispredict = i_jump_code[JC_VALID_BIT] && (taken != i_predict);
    end

endmodule

// File: rtl/exec_commit.sv
module exec_commit (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  exec_pipe_pkg::exec_op_t          i_op,
    input  logic                             i_submit,
    input  logic                             i_next_ready,
    input  logic [cpu_isa_pkg::DATA_W-1:0]   i_alu_out,
    input  logic [cpu_isa_pkg::FLAG_CNT-1:0] i_alu_flags,
    input  exec_pipe_pkg::branch_dec_t       i_dec,
    output logic                             o_ready,
    output logic [cpu_isa_pkg::FLAG_CNT-1:0] o_flags,
    output logic [cpu_isa_pkg::DATA_W-1:0]   o_exec_pc,
    output logic                             o_pc_update,
    output logic                             o_flush,
    output exec_pipe_pkg::exec_result_t      o_result,
    output logic                             o_submit
);

    import cpu_isa_pkg::*;

    logic raw_hazard;
    logic accept;

    // Pending result reaches the register file one cycle after o_submit
    assign raw_hazard = o_submit && o_result.we &&
                        ((o_result.dst_sel == i_op.l_sel) ||
                         (!i_op.use_imm && (o_result.dst_sel == i_op.r_sel)));

    // Upstream is being redirected during the flush cycle
    assign o_ready     = i_next_ready && !raw_hazard && !o_flush;
    assign accept      = i_submit && o_ready;
    assign o_pc_update = accept;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_exec_pc <= PC_RESET;
        end else if (accept) begin
            if (i_dec.taken) begin
                o_exec_pc <= i_alu_out;
            end else begin
                o_exec_pc <= o_exec_pc + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_flags  <= '0;
            o_flush  <= 1'b0;
            o_submit <= 1'b0;
        end else begin
            if (accept && i_op.flags_we) begin
                o_flags <= i_alu_flags;
            end
            o_flush  <= accept && i_dec.mispredict;
            o_submit <= accept;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_result.data    <= i_alu_out;
            o_result.dst_sel <= i_op.dst_sel;
            o_result.we      <= i_op.dst_we;
        end
    end

    // One flush per mispredicted jump
    a_flush_single: assert property (@(posedge i_clk) disable iff (i_rst)
        o_flush |=> !o_flush)
        else $error("exec_commit: flush high for two cycles");

    // Every result goes back to a handshake on the upstream side
    a_submit_after_accept: assert property (@(posedge i_clk) disable iff (i_rst)
        o_submit |-> $past(i_submit && o_ready))
        else $error("exec_commit: result without acceptance");

endmodule

// File: rtl/exec_top.sv
module exec_top (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  exec_pipe_pkg::exec_op_t        i_op,
    input  logic                           i_submit,
    output logic                           o_ready,
    input  logic                           i_next_ready,
    input  exec_pipe_pkg::wb_t             i_wb,
    output exec_pipe_pkg::exec_result_t    o_result,
    output logic                           o_submit,
    output logic [cpu_isa_pkg::DATA_W-1:0] o_exec_pc,
    output logic                           o_pc_update,
    output logic                           o_flush
);

    import cpu_isa_pkg::*;
    import exec_pipe_pkg::*;

    logic [DATA_W-1:0]   l_data;
    logic [DATA_W-1:0]   r_data;
    logic [DATA_W-1:0]   alu_r;
    logic [DATA_W-1:0]   alu_out;
    logic [FLAG_CNT-1:0] alu_flags;
    logic [FLAG_CNT-1:0] flags_q;
    logic                alu_carry;
    branch_dec_t         dec;

    assign alu_r     = i_op.use_imm ? i_op.imm : r_data;
    assign alu_carry = flags_q[FLAG_C] & i_op.carry_en;

    reg_file u_reg_file (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_l_sel  (i_op.l_sel),
        .i_r_sel  (i_op.r_sel),
        .i_wb     (i_wb),
        .o_l_data (l_data),
        .o_r_data (r_data)
    );

    alu u_alu (
        .i_l     (l_data),
        .i_r     (alu_r),
        .i_mode  (i_op.alu_mode),
        .i_carry (alu_carry),
        .o_out   (alu_out),
        .o_flags (alu_flags)
    );

    // Condition is tested against the flags stored before this operation
    branch_unit u_branch_unit (
        .i_jump_code (i_op.jump_code),
        .i_predict   (i_op.predict),
        .i_flags     (flags_q),
        .o_dec       (dec)
    );

    exec_commit u_exec_commit (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_op         (i_op),
        .i_submit     (i_submit),
        .i_next_ready (i_next_ready),
        .i_alu_out    (alu_out),
        .i_alu_flags  (alu_flags),
        .i_dec        (dec),
        .o_ready      (o_ready),
        .o_flags      (flags_q),
        .o_exec_pc    (o_exec_pc),
        .o_pc_update  (o_pc_update),
        .o_flush      (o_flush),
        .o_result     (o_result),
        .o_submit     (o_submit)
    );

endmodule

// File: verification/exec_tb.sv
module exec_tb;

    import cpu_isa_pkg::*;
    import exec_pipe_pkg::*;

    localparam int N_OPS          = 400;
    localparam int TIMEOUT_CYCLES = N_OPS * 8 + 100;

    logic         i_clk;
    logic         i_rst;
    exec_op_t     i_op;
    logic         i_submit;
    logic         o_ready;
    logic         i_next_ready;
    wb_t          i_wb;
    exec_result_t o_result;
    logic         o_submit;
    logic [DATA_W-1:0] o_exec_pc;
    logic         o_pc_update;
    logic         o_flush;

    integer seed = 32'h61e0292b;
    int     n_accepted = 0;
    int     cycle_cnt = 0;

    // Reference state of the execute stage
    logic [DATA_W-1:0]   m_regs [REG_CNT];
    logic [FLAG_CNT-1:0] m_flags;
    logic [DATA_W-1:0]   m_pc;
    exec_result_t        exp_result;
    logic                exp_submit;
    logic                exp_flush;

    exec_top DUT (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_op         (i_op),
        .i_submit     (i_submit),
        .o_ready      (o_ready),
        .i_next_ready (i_next_ready),
        .i_wb         (i_wb),
        .o_result     (o_result),
        .o_submit     (o_submit),
        .o_exec_pc    (o_exec_pc),
        .o_pc_update  (o_pc_update),
        .o_flush      (o_flush)
    );

    initial i_clk = 1'b0;
    always #4 i_clk = ~i_clk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "check %s failed", name);
        end
    endtask

    task automatic model_alu(input logic [DATA_W-1:0] l, input logic [DATA_W-1:0] r,
                             input alu_mode_t mode, input logic cin,
                             output logic [DATA_W-1:0] out,
                             output logic [FLAG_CNT-1:0] flags);
        logic [DATA_W:0] sum;
        logic            c;
        logic            o;
        c = 1'b0;
        o = 1'b0;
        case (mode)
            ALU_ADD: begin
                sum = {1'b0, l} + {1'b0, r} + cin;
                out = sum[DATA_W-1:0];
                c   = sum[DATA_W];
                o   = (l[DATA_W-1] == r[DATA_W-1]) && (out[DATA_W-1] != l[DATA_W-1]);
            end
            ALU_SUB: begin
                out = l - r;
                // Borrow when the right operand is larger
                c   = (l < r);
                o   = (l[DATA_W-1] != r[DATA_W-1]) && (out[DATA_W-1] != l[DATA_W-1]);
            end
            ALU_AND: out = l & r;
            ALU_OR:  out = l | r;
            ALU_XOR: out = l ^ r;
            ALU_SHL: begin
                out = l << 1;
                c   = l[DATA_W-1];
            end
            ALU_SHR: begin
                out = l >> 1;
                c   = l[0];
            end
            default: out = r;
        endcase
        flags         = '0;
        flags[FLAG_Z] = (out == 0);
        flags[FLAG_C] = c;
        flags[FLAG_N] = out[DATA_W-1];
        flags[FLAG_O] = o;
        flags[FLAG_P] = ~^out;
    endtask

    function automatic logic cond_taken(input jump_cond_t code,
                                        input logic [FLAG_CNT-1:0] f);
        case (code)
            JC_UNCOND: return 1'b1;
            JC_CARRY:  return f[FLAG_C];
            JC_EQ:     return f[FLAG_Z];
            JC_LT:     return f[FLAG_N];
            JC_GT:     return !f[FLAG_N] && !f[FLAG_Z];
            JC_LE:     return f[FLAG_N] || f[FLAG_Z];
            JC_GE:     return !f[FLAG_N];
            JC_NE:     return !f[FLAG_Z];
            JC_OVF:    return f[FLAG_O];
            JC_PAR:    return f[FLAG_P];
            JC_GTU:    return !f[FLAG_C] && !f[FLAG_Z];
            JC_GEU:    return !f[FLAG_C];
            JC_LEU:    return f[FLAG_C] || f[FLAG_Z];
            default:   return 1'b0;
        endcase
    endfunction

    task automatic random_op(output exec_op_t op);
        logic [31:0] a;
        logic [31:0] b;
        a = $random(seed);
        b = $random(seed);
        op.alu_mode  = alu_mode_t'(a[2:0]);
        op.carry_en  = a[3];
        op.l_sel     = a[6:4];
        op.r_sel     = a[9:7];
        op.use_imm   = a[10];
        // Small immediates now and then reach the zero and carry cases
        op.imm       = (b[17:16] == 2'b00) ? {12'h000, b[3:0]} : b[15:0];
        op.dst_sel   = a[13:11];
        op.dst_we    = (a[15:14] != 2'b00);
        op.flags_we  = a[16] | a[17];
        op.predict   = a[18];
        op.jump_code = a[24:20];
    endtask

    task automatic step_cycle();
        logic                hazard;
        logic                exp_ready;
        logic                accept;
        logic                taken;
        logic [DATA_W-1:0]   l;
        logic [DATA_W-1:0]   r;
        logic [DATA_W-1:0]   out;
        logic [FLAG_CNT-1:0] flags;
        exec_op_t            op;
        logic [31:0]         rnd;

        hazard = exp_submit && exp_result.we &&
                 ((exp_result.dst_sel == i_op.l_sel) ||
                  (!i_op.use_imm && (exp_result.dst_sel == i_op.r_sel)));
        exp_ready = i_next_ready && !hazard && !exp_flush;
        accept    = i_submit && exp_ready;

        check("ready", exp_ready, o_ready);
        check("submit", exp_submit, o_submit);
        check("flush", exp_flush, o_flush);
        check("exec_pc", m_pc, o_exec_pc);
        check("pc_update", accept, o_pc_update);
        if (exp_submit) begin
            check("result", exp_result, o_result);
        end

        // Next stage returns the result one cycle after o_submit
        i_wb <= '{we: o_submit && o_result.we, sel: o_result.dst_sel, data: o_result.data};

        if (accept) begin
            l = m_regs[i_op.l_sel];
            r = i_op.use_imm ? i_op.imm : m_regs[i_op.r_sel];
            model_alu(l, r, i_op.alu_mode, i_op.carry_en && m_flags[FLAG_C], out, flags);
            taken      = cond_taken(i_op.jump_code, m_flags);
            exp_flush  = i_op.jump_code[JC_VALID_BIT] && (taken != i_op.predict);
            exp_result = '{data: out, dst_sel: i_op.dst_sel, we: i_op.dst_we};
            exp_submit = 1'b1;
            if (i_op.dst_we) begin
                m_regs[i_op.dst_sel] = out;
            end
            if (i_op.flags_we) begin
                m_flags = flags;
            end
            m_pc = taken ? out : m_pc + 1'b1;
            n_accepted++;
        end else begin
            exp_submit = 1'b0;
            exp_flush  = 1'b0;
        end

        rnd = $random(seed);
        if (n_accepted >= N_OPS) begin
            i_submit <= 1'b0;
        end else if (!(i_submit && !accept)) begin
            random_op(op);
            i_op     <= op;
            i_submit <= (rnd[1:0] != 2'b00);
        end
        i_next_ready <= (rnd[3:2] != 2'b00);
    endtask

    always @(posedge i_clk) begin
        if (!i_rst) begin
            step_cycle();
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d operations accepted",
                     cycle_cnt, n_accepted, N_OPS);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    initial begin
        i_rst        = 1'b1;
        i_op         = '0;
        i_submit     = 1'b0;
        i_next_ready = 1'b0;
        i_wb         = '0;
        m_flags      = '0;
        m_pc         = PC_RESET;
        exp_result   = '0;
        exp_submit   = 1'b0;
        exp_flush    = 1'b0;
        for (int i = 0; i < REG_CNT; i++) begin
            m_regs[i] = '0;
        end
        repeat (16) @(posedge i_clk);
        i_rst <= 1'b0;
        wait (n_accepted == N_OPS);
        // Let the last result and writeback drain
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: project.f
rtl/cpu_isa_pkg.sv
rtl/exec_pipe_pkg.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/exec_commit.sv
rtl/exec_top.sv
verification/exec_tb.sv

// File: Bender.yml
package:
  name: exec_stage

dependencies: {}

sources:
  - files:
      - rtl/cpu_isa_pkg.sv
      - rtl/exec_pipe_pkg.sv
      - rtl/reg_file.sv
      - rtl/alu.sv
      - rtl/branch_unit.sv
      - rtl/exec_commit.sv
      - rtl/exec_top.sv
  - target: test
    files:
      - verification/exec_tb.sv
